// ==== hw/fp_div_pkg.sv ====
`default_nettype none

package fp_div_pkg;

	// Exponent bias of the single-precision format.
	localparam int EXP_BIAS = 127;

	typedef struct packed {
		logic        sign;
		logic [7:0]  exp;
		logic [22:0] frac;
	} fp32_t;

	typedef enum logic [1:0] {
		FP_ZERO = 2'b00,
		FP_NORM = 2'b01,
		FP_INF  = 2'b10,
		FP_NAN  = 2'b11
	} fp_class_t;

	// Operand after classification.
	// Mant carries the hidden bit and is zero for non-normal classes.
	typedef struct packed {
		logic        sign;
		fp_class_t   cls;
		logic [7:0]  exp;
		logic [23:0] mant;
	} op_info_t;

	typedef struct packed {
		logic invalid;
		logic div_zero;
		logic overflow;
		logic underflow;
	} fp_flags_t;

	// Canonical quiet NaN.
	localparam fp32_t QNAN = 32'h7FC0_0000;

endpackage

`default_nettype wire

// ==== hw/fp_unpack.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_unpack (
	input  wire fp_div_pkg::fp32_t x,
	output fp_div_pkg::op_info_t  info
);

	import fp_div_pkg::*;

	logic exp_zero;
	logic exp_max;
	logic frac_zero;

	assign exp_zero  = (x.exp == 8'h00);
	assign exp_max   = (x.exp == 8'hFF);
	assign frac_zero = (x.frac == 23'd0);

	always_comb begin
		info.sign = x.sign;
		info.exp  = x.exp;
		if (exp_zero) begin
			// Subnormals flush to zero.
			info.cls  = FP_ZERO;
			info.mant = 24'd0;
		end else if (exp_max) begin
			if (frac_zero) begin
				info.cls = FP_INF;
			end else begin
				info.cls = FP_NAN;
			end
			info.mant = 24'd0;
		end else begin
			// Hidden bit restored.
			info.cls  = FP_NORM;
			info.mant = {1'b1, x.frac};
		end
	end

endmodule

`default_nettype wire

// ==== hw/mant_divider.sv ====
`timescale 1ns/10ps
`default_nettype none

module mant_divider #(
	parameter int QUOT_W = 27
) (
	input  wire               CLK,
	input  wire               rst_n,
	input  wire               start,
	input  wire [23:0]        dividend,
	input  wire [23:0]        divisor,
	output logic [QUOT_W-1:0] quotient,
	output logic              rem_nonzero,
	output logic              done
);

	localparam int CNT_W = $clog2(QUOT_W);
	localparam int REM_W = 25;

	typedef enum logic [1:0] {
		IDLE    = 2'b00,
		DIVIDE  = 2'b01,
		CORRECT = 2'b11,
		FINISH  = 2'b10
	} state_t;

	state_t state;
	state_t state_nxt;

	logic [CNT_W-1:0] count;
	logic             last_iter;

	logic [23:0]      divisor_q;
	logic [REM_W-1:0] div_ext;
	logic [REM_W-1:0] rem_q;
	logic [REM_W-1:0] rem_shift;
	logic [REM_W-1:0] rem_next;
	logic [REM_W-1:0] rem_fix;

	assign last_iter = (count == CNT_W'(QUOT_W - 1));
	assign div_ext   = {1'b0, divisor_q};

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (start) begin
					state_nxt = DIVIDE;
				end
			end
			DIVIDE: begin
				if (last_iter) begin
					state_nxt = CORRECT;
				end
			end
			CORRECT: begin
				state_nxt = FINISH;
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			count <= '0;
			done  <= 1'b0;
		end else begin
			state <= state_nxt;
			done  <= (state == FINISH);
			if (state == DIVIDE) begin
				count <= count + 1'b1;
			end else begin
				count <= '0;
			end
		end
	end

	// Partial remainder ALU.
	always_comb begin
		// First step works on the unshifted dividend, so the top bit has weight one.
		if (count == '0) begin
			rem_shift = rem_q;
		end else begin
			rem_shift = rem_q << 1;
		end
		if (rem_q[REM_W-1]) begin
			rem_next = rem_shift + div_ext;
		end else begin
			rem_next = rem_shift - div_ext;
		end
		// Negative final remainder gets the divisor back.
		if (rem_q[REM_W-1]) begin
			rem_fix = rem_q + div_ext;
		end else begin
			rem_fix = rem_q;
		end
	end

	always_ff @(posedge CLK) begin
		case (state)
			IDLE: begin
				if (start) begin
					rem_q     <= {1'b0, dividend};
					divisor_q <= divisor;
				end
			end
			DIVIDE: begin
				rem_q    <= rem_next;
				quotient <= {quotient[QUOT_W-2:0], ~rem_next[REM_W-1]};
			end
			CORRECT: begin
				rem_nonzero <= (rem_fix != '0);
			end
			default: begin
				rem_q <= rem_q;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/fp_round_pack.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_round_pack #(
	parameter int QUOT_W = 27
) (
	input  wire                       sign,
	input  wire signed [9:0]          exp_in,
	input  wire fp_div_pkg::op_info_t a_info,
	input  wire fp_div_pkg::op_info_t b_info,
	input  wire [QUOT_W-1:0]          quotient,
	input  wire                       rem_nonzero,
	output fp_div_pkg::fp32_t         result,
	output fp_div_pkg::fp_flags_t     flags
);

	import fp_div_pkg::*;

	logic              q_top;
	logic [QUOT_W-1:0] q_norm;
	logic signed [9:0] exp_norm;
	logic signed [9:0] exp_rnd;
	logic [23:0]       mant;
	logic              guard;
	logic              sticky;
	logic              round_up;
	logic [24:0]       mant_rnd;

	logic  nan_case;
	fp32_t inf_word;
	fp32_t zero_word;
	fp32_t norm_word;

	// Quotient is in [0.5, 2); at most one left shift normalizes it.
	assign q_top    = quotient[QUOT_W-1];
	assign q_norm   = q_top ? quotient : {quotient[QUOT_W-2:0], 1'b0};
	assign exp_norm = q_top ? exp_in : exp_in - 10'sd1;

	assign mant   = q_norm[QUOT_W-1 -: 24];
	assign guard  = q_norm[QUOT_W-25];
	assign sticky = (|q_norm[QUOT_W-26:0]) | rem_nonzero;

	// Nearest even.
	assign round_up = guard & (sticky | mant[0]);
	assign mant_rnd = {1'b0, mant} + {24'd0, round_up};
	assign exp_rnd  = mant_rnd[24] ? exp_norm + 10'sd1 : exp_norm;

	assign inf_word  = '{sign: sign, exp: 8'hFF, frac: 23'd0};
	assign zero_word = '{sign: sign, exp: 8'h00, frac: 23'd0};
	// On a carry out the fraction bits are all zero.
	assign norm_word = '{sign: sign, exp: exp_rnd[7:0], frac: mant_rnd[22:0]};

	assign nan_case = (a_info.cls == FP_NAN) || (b_info.cls == FP_NAN) ||
		((a_info.cls == FP_ZERO) && (b_info.cls == FP_ZERO)) ||
		((a_info.cls == FP_INF) && (b_info.cls == FP_INF));

	always_comb begin
		result = norm_word;
		flags  = '0;
		if (nan_case) begin
			result        = QNAN;
			flags.invalid = 1'b1;
		end else if (a_info.cls == FP_INF) begin
			result = inf_word;
		end else if (b_info.cls == FP_ZERO) begin
			result         = inf_word;
			flags.div_zero = 1'b1;
		end else if ((a_info.cls == FP_ZERO) || (b_info.cls == FP_INF)) begin
			result = zero_word;
		end else if (exp_rnd >= 10'sd255) begin
			result         = inf_word;
			flags.overflow = 1'b1;
		end else if (exp_rnd <= 10'sd0) begin
			// Results below the normal range flush to zero.
			result          = zero_word;
			flags.underflow = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/fp_div_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_div_top #(
	parameter int QUOT_W = 27
) (
	input  wire                        CLK,
	input  wire                        rst_n,
	input  wire                        in_valid,
	input  wire fp_div_pkg::fp32_t     a,
	input  wire fp_div_pkg::fp32_t     b,
	output logic                       in_ready,
	output logic                       out_valid,
	output fp_div_pkg::fp32_t          result,
	output fp_div_pkg::fp_flags_t      flags
);

	import fp_div_pkg::*;

	op_info_t a_info;
	op_info_t b_info;
	op_info_t a_info_q;
	op_info_t b_info_q;

	logic              accept;
	logic              busy;
	logic              sign_q;
	logic signed [9:0] exp_diff;
	logic signed [9:0] exp_q;

	logic [QUOT_W-1:0] quotient;
	logic              rem_nonzero;
	logic              div_done;

	fp32_t     rp_result;
	fp_flags_t rp_flags;

	fp_unpack u_unpack_a (
		.x    (a),
		.info (a_info)
	);

	fp_unpack u_unpack_b (
		.x    (b),
		.info (b_info)
	);

	assign in_ready = !busy;
	assign accept   = in_valid && in_ready;

	// Biased result exponent before normalization.
	assign exp_diff = $signed({2'b00, a_info.exp}) - $signed({2'b00, b_info.exp}) +
		$signed(10'(EXP_BIAS));

	// The divider always runs its full count, specials included.
	mant_divider #(
		.QUOT_W (QUOT_W)
	) u_divider (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.start       (accept),
		.dividend    (a_info.mant),
		.divisor     (b_info.mant),
		.quotient    (quotient),
		.rem_nonzero (rem_nonzero),
		.done        (div_done)
	);

	fp_round_pack #(
		.QUOT_W (QUOT_W)
	) u_round_pack (
		.sign        (sign_q),
		.exp_in      (exp_q),
		.a_info      (a_info_q),
		.b_info      (b_info_q),
		.quotient    (quotient),
		.rem_nonzero (rem_nonzero),
		.result      (rp_result),
		.flags       (rp_flags)
	);

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= div_done;
			if (accept) begin
				busy <= 1'b1;
			end else if (div_done) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			a_info_q <= a_info;
			b_info_q <= b_info;
			sign_q   <= a.sign ^ b.sign;
			exp_q    <= exp_diff;
		end
		// Held until the next division completes.
		if (div_done) begin
			result <= rp_result;
			flags  <= rp_flags;
		end
	end

endmodule

`default_nettype wire

// ==== tb/fp_div_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_div_assert (
	input wire CLK,
	input wire rst_n,
	input wire in_valid,
	input wire in_ready,
	input wire out_valid
);

	int fail_count = 0;

	// A result is presented for one cycle only.
	assert property (@(posedge CLK) disable iff (!rst_n) out_valid |=> !out_valid)
		else begin
			$error("out_valid high on two consecutive cycles");
			fail_count = fail_count + 1;
		end

	assert property (@(posedge CLK) disable iff (!rst_n)
		(in_valid && in_ready) |=> !in_ready)
		else begin
			$error("in_ready still high after an accepted division");
			fail_count = fail_count + 1;
		end

	// Ready returns together with the result.
	assert property (@(posedge CLK) disable iff (!rst_n) $rose(in_ready) |-> out_valid)
		else begin
			$error("in_ready rose without out_valid");
			fail_count = fail_count + 1;
		end

	assert property (@(posedge CLK) !rst_n |-> !out_valid)
		else begin
			$error("out_valid high during reset");
			fail_count = fail_count + 1;
		end

endmodule

bind fp_div_top fp_div_assert u_handshake_assert (
	.CLK       (CLK),
	.rst_n     (rst_n),
	.in_valid  (in_valid),
	.in_ready  (in_ready),
	.out_valid (out_valid)
);

`default_nettype wire

// ==== tb/fp_div_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_div_checker #(
	parameter int QUOT_W = 27
) (
	input  wire                        CLK,
	input  wire                        rst_n,
	input  wire                        in_valid,
	input  wire                        in_ready,
	input  wire fp_div_pkg::fp32_t     a,
	input  wire fp_div_pkg::fp32_t     b,
	input  wire                        out_valid,
	input  wire fp_div_pkg::fp32_t     result,
	input  wire fp_div_pkg::fp_flags_t flags,
	output int                         checked,
	output int                         errors
);

	import fp_div_pkg::*;

	typedef struct packed {
		fp32_t     result;
		fp_flags_t flags;
	} expect_t;

	typedef struct packed {
		fp32_t       a;
		fp32_t       b;
		logic [31:0] accept_edge;
	} pending_t;

	pending_t    pending[$];
	pending_t    cur;
	expect_t     want;
	logic [31:0] edge_count;
	int          latency;

	function automatic fp_class_t classify(input fp32_t x);
		if (x.exp == 8'h00) begin
			return FP_ZERO;
		end else if (x.exp != 8'hFF) begin
			return FP_NORM;
		end
		return (x.frac == 23'd0) ? FP_INF : FP_NAN;
	endfunction

	// Single-precision division, subnormals flushed, nearest even.
	function automatic expect_t ref_divide(input fp32_t x, input fp32_t y);
		expect_t     e;
		fp_class_t   cx;
		fp_class_t   cy;
		logic [63:0] num;
		logic [63:0] den;
		logic [63:0] q;
		logic [23:0] mant;
		logic [24:0] mant_r;
		logic        guard;
		logic        sticky;
		int          ex;
		cx       = classify(x);
		cy       = classify(y);
		e.flags  = '0;
		e.result = '{sign: x.sign ^ y.sign, exp: 8'h00, frac: 23'd0};
		if (cx == FP_NAN || cy == FP_NAN || (cx == cy && cx != FP_NORM)) begin
			e.result        = 32'h7FC0_0000;
			e.flags.invalid = 1'b1;
		end else if (cx == FP_INF || cy == FP_ZERO) begin
			e.result.exp     = 8'hFF;
			e.flags.div_zero = (cx != FP_INF);
		end else if (cx == FP_NORM && cy == FP_NORM) begin
			// Far more quotient bits than the guard needs.
			num    = {1'b1, x.frac, 40'd0};
			den    = {40'd0, 1'b1, y.frac};
			q      = num / den;
			sticky = (num % den) != 64'd0;
			ex     = int'(x.exp) - int'(y.exp) + 127;
			if (!q[40]) begin
				q  = q << 1;
				ex = ex - 1;
			end
			mant   = q[40:17];
			guard  = q[16];
			sticky = sticky | (q[15:0] != 16'd0);
			mant_r = {1'b0, mant} + ((guard && (sticky || mant[0])) ? 25'd1 : 25'd0);
			if (mant_r[24]) begin
				mant_r = mant_r >> 1;
				ex     = ex + 1;
			end
			if (ex >= 255) begin
				e.result.exp     = 8'hFF;
				e.flags.overflow = 1'b1;
			end else if (ex <= 0) begin
				e.flags.underflow = 1'b1;
			end else begin
				e.result.exp  = 8'(ex);
				e.result.frac = mant_r[22:0];
			end
		end
		return e;
	endfunction

	always @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			pending.delete();
			edge_count = '0;
			checked    = 0;
			errors     = 0;
		end else begin
			edge_count = edge_count + 32'd1;
			if (out_valid) begin
				if (pending.size() == 0) begin
					$display("out_valid rose with no division pending at edge %0d", edge_count);
					errors = errors + 1;
				end else begin
					cur     = pending.pop_front();
					want    = ref_divide(cur.a, cur.b);
					checked = checked + 1;
					// Out_valid is seen one edge after the edge that raised it.
					latency = int'(edge_count - cur.accept_edge) - 1;
					if (result !== want.result || flags !== want.flags) begin
						$display("error test %0d result %h expected %h flags %h expected %h, a %h b %h",
							checked, result, want.result, flags, want.flags, cur.a, cur.b);
						errors = errors + 1;
					end else if (latency != QUOT_W + 3) begin
						$display("test %0d took %0d cycles from accept to out_valid instead of %0d",
							checked, latency, QUOT_W + 3);
						errors = errors + 1;
					end else begin
						$display("test %0d ok %h / %h = %h flags %h",
							checked, cur.a, cur.b, result, flags);
					end
				end
			end
			if (in_valid && in_ready) begin
				pending.push_back('{a: a, b: b, accept_edge: edge_count});
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/fp_div_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module fp_div_tb;

	import fp_div_pkg::*;

	localparam int QUOT_W     = 27;
	localparam int HALF_CYCLE = 4;
	localparam int RESET_CYC  = 10;
	localparam int N_DIRECTED = 27;
	localparam int N_NORMAL   = 200;
	localparam int N_ANY      = 100;
	localparam int N_BUSY     = 2;
	localparam int N_TESTS    = N_DIRECTED + N_NORMAL + N_ANY + N_BUSY;
	// Each division takes QUOT_W+3 cycles plus a few for the handshake.
	localparam int WATCHDOG_CYC = N_TESTS * (QUOT_W + 6) + RESET_CYC + 200;
	localparam logic [31:0] SEED = 32'h702b;

	logic      CLK;
	logic      rst_n;
	logic      in_valid;
	fp32_t     a;
	fp32_t     b;
	logic      in_ready;
	logic      out_valid;
	fp32_t     result;
	fp_flags_t flags;
	int        issued;
	int        checked;
	int        errors;
	fp32_t     x;
	fp32_t     y;

	fp_div_top #(
		.QUOT_W (QUOT_W)
	) fp_div_top_i (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.a         (a),
		.b         (b),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.result    (result),
		.flags     (flags)
	);

	fp_div_checker #(
		.QUOT_W (QUOT_W)
	) u_checker (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.a         (a),
		.b         (b),
		.out_valid (out_valid),
		.result    (result),
		.flags     (flags),
		.checked   (checked),
		.errors    (errors)
	);

	always #HALF_CYCLE CLK = ~CLK;

	task automatic divide(input fp32_t op_a, input fp32_t op_b);
		@(negedge CLK);
		while (!in_ready) begin
			@(negedge CLK);
		end
		in_valid = 1'b1;
		a        = op_a;
		b        = op_b;
		issued   = issued + 1;
		@(negedge CLK);
		in_valid = 1'b0;
	endtask

	// Strobes while busy must be dropped.
	task automatic strobe_while_busy(input fp32_t op_a, input fp32_t op_b);
		divide(op_a, op_b);
		in_valid = 1'b1;
		a        = op_b;
		b        = op_a;
		repeat (QUOT_W / 2) begin
			@(negedge CLK);
		end
		in_valid = 1'b0;
	endtask

	function automatic fp32_t random_normal();
		fp32_t r;
		r     = $urandom;
		r.exp = 8'(64 + $urandom_range(127, 0));
		return r;
	endfunction

	initial begin
		void'($urandom(SEED));
		CLK      = 1'b0;
		rst_n    = 1'b0;
		in_valid = 1'b0;
		a        = '0;
		b        = '0;
		issued   = 0;
		repeat (RESET_CYC) begin
			@(posedge CLK);
		end
		@(negedge CLK);
		rst_n = 1'b1;
		// Exact and rounded quotients.
		divide(32'h40C0_0000, 32'h4040_0000);
		divide(32'h3F80_0000, 32'h3F80_0000);
		divide(32'hC100_0000, 32'h4000_0000);
		divide(32'h3F80_0000, 32'h4040_0000);
		divide(32'h4000_0000, 32'h4040_0000);
		divide(32'h3F80_0000, 32'h40E0_0000);
		divide(32'h3F80_0000, 32'h4120_0000);
		// Near-ties at the top of the binade.
		divide(32'h3F80_0000, 32'h3F80_0001);
		divide(32'h3FFF_FFFE, 32'h3FFF_FFFF);
		divide(32'h3FFF_FFFF, 32'h3F80_0001);
		// Range limits and flushed subnormals.
		divide(32'h7F00_0000, 32'h3E80_0000);
		divide(32'h7F7F_FFFF, 32'h3F00_0000);
		divide(32'h0080_0000, 32'h7F00_0000);
		divide(32'h0080_0000, 32'h4000_0000);
		divide(32'h0080_0000, 32'h3F80_0000);
		divide(32'h0040_0000, 32'h3F80_0000);
		divide(32'h3F80_0000, 32'h0000_0001);
		// Special operands.
		divide(32'h7FC0_0000, 32'h3F80_0000);
		divide(32'h3F80_0000, 32'h7F80_0001);
		divide(32'h0000_0000, 32'h8000_0000);
		divide(32'h7F80_0000, 32'hFF80_0000);
		divide(32'hC000_0000, 32'h0000_0000);
		divide(32'hFF80_0000, 32'h4000_0000);
		divide(32'h4000_0000, 32'hFF80_0000);
		divide(32'h8000_0000, 32'h4000_0000);
		divide(32'h7F80_0000, 32'h0000_0000);
		divide(32'h0000_0000, 32'h7F80_0000);
		for (int i = 0; i < N_NORMAL; i++) begin
			x = random_normal();
			y = random_normal();
			divide(x, y);
		end
		for (int i = 0; i < N_ANY; i++) begin
			x = $urandom;
			y = $urandom;
			divide(x, y);
		end
		strobe_while_busy(32'h4049_0FDB, 32'h402D_F854);
		strobe_while_busy(32'h7F80_0000, 32'h0000_0000);
		wait (checked == issued);
		repeat (QUOT_W + 6) begin
			@(negedge CLK);
		end
		$display("%0d divisions sent, %0d checked, %0d errors, %0d assertion failures",
			issued, checked, errors, fp_div_top_i.u_handshake_assert.fail_count);
		if (errors == 0 && checked == issued &&
			fp_div_top_i.u_handshake_assert.fail_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYC) begin
			@(posedge CLK);
		end
		$display("watchdog expired after %0d cycles with %0d of %0d results checked",
			WATCHDOG_CYC, checked, issued);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
hw/fp_div_pkg.sv
hw/fp_unpack.sv
hw/mant_divider.sv
hw/fp_round_pack.sv
hw/fp_div_top.sv
tb/fp_div_assert.sv
tb/fp_div_checker.sv
tb/fp_div_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module fp_div_tb \
	-Mdir obj_dir \
	-f src.f

./obj_dir/Vfp_div_tb 2>&1 | tee sim.log

if grep -qx "TEST PASSED" sim.log; then
	exit 0
fi
echo "run.sh: simulation did not pass, see sim.log"
exit 1
